/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; exits nonzero on failure.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f --top-module cart_tester_tb -o cart_tester_sim > build.log 2>&1 \
	&& ./obj_dir/cart_tester_sim > sim.log 2>&1 \
	|| { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation reported failure"; exit 1; }
echo "Simulation passed"
exit 0

/* tb/cart_tester_props.sv */
`timescale 1ns/10ps
`default_nettype none

module cart_tester_props(
	input wire        cpuclk,
	input wire        f_reset,
	input wire        awvalid,
	input wire        wvalid,
	input wire        awready,
	input wire        wready,
	input wire        bvalid,
	input wire        bready,
	input wire        rvalid,
	input wire        rready,
	input wire [14:0] cart_adr,
	input wire        cart_rd,
	input wire        cart_wr,
	input wire        cart_cs_rom,
	input wire        cart_cs_xram,
	input wire        cart_done
);

	logic       pending;
	logic [2:0] wait_cnt; // Edges since the qualified strobe.
	logic       qual;

	assign qual = (cart_rd && cart_cs_rom) || (cart_wr && cart_cs_xram && cart_adr[13]);

	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			pending  <= 1'b0;
			wait_cnt <= '0;
		end else if (cart_done) begin
			pending <= 1'b0;
		end else if (qual) begin
			pending  <= 1'b1;
			wait_cnt <= '0;
		end else if (pending && wait_cnt != 3'd7) begin
			wait_cnt <= wait_cnt + 3'd1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Handshake rules.
	// ~~~~~~~~~~~~~~~~~~~~
	assert property (@(posedge cpuclk) disable iff (f_reset) bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");
	assert property (@(posedge cpuclk) disable iff (f_reset) rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");
	assert property (@(posedge cpuclk) disable iff (f_reset)
		(awready || wready) |-> awready && wready && awvalid && wvalid && !bvalid && !rvalid)
		else $error("write accepted without both valids or while a response is held");
	assert property (@(posedge cpuclk) disable iff (f_reset) !(pending && wait_cnt >= 3'd4))
		else $error("cart_done late after a qualified strobe");

endmodule

bind cart_tester_top cart_tester_props props(
	.cpuclk(cpuclk), .f_reset(f_reset),
	.awvalid(awvalid), .wvalid(wvalid),
	.awready(awready), .wready(wready),
	.bvalid(bvalid), .bready(bready),
	.rvalid(rvalid), .rready(rready),
	.cart_adr(cart_adr), .cart_rd(cart_rd), .cart_wr(cart_wr),
	.cart_cs_rom(cart_cs_rom), .cart_cs_xram(cart_cs_xram),
	.cart_done(cart_done)
);

`default_nettype wire

/* tb/cart_tester_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "tester_defs.svh"

module cart_tester_tb;
	import tester_pkg::*;

	localparam int TMO = 60; // Cycles allowed for any one wait.

	logic        cpuclk, f_reset;
	bus_addr_t   awaddr, araddr;
	logic        awvalid, wvalid, bready, arvalid, rready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	wire         awready, wready, bvalid, arready, rvalid;
	wire  [1:0]  bresp, rresp;
	wire  [31:0] rdata;
	wire  [15:0] led;
	logic [15:0] sw;
	wire  [7:0]  pa_out, cart_data_out;
	logic [7:0]  pa_in, cart_data_in;
	logic [14:0] cart_adr;
	logic        cart_rd, cart_wr, cart_cs_rom, cart_cs_xram;
	wire         cart_done;

	logic [31:0] lfsr;
	logic [7:0]  sys_m [0:4095];
	logic [7:0]  cart_m [0:4095];
	logic [15:0] led_m;
	logic [7:0]  pa_m;
	logic [31:0] snap_m;
	logic [7:0]  rd_exp [$];
	logic [8:0]  cart_exp [$]; // {is_read, byte}.
	logic [8:0]  cart_ent;
	logic [15:0] addr_list [0:15];
	logic        stress;
	int          mis_errs, other_errs;

	cart_tester_top uut(.*);

	initial begin
		cpuclk = 1'b0;
		forever #50 cpuclk = ~cpuclk;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Random source and reference model.
	// ~~~~~~~~~~~~~~~~~~~~
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_val(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	function automatic logic [7:0] expect_byte(input logic [15:0] a);
		if ((a >> 12) == (`TESTER_SYSRAM_BASE >> 12))
			return sys_m[a[11:0]];
		if ((a >> 12) == (`TESTER_CARTRAM_BASE >> 12))
			return cart_m[a[11:0]];
		if ((a >> 2) == (`TESTER_SNAP_BASE >> 2))
			return snap_m[8*a[1:0] +: 8];
		case (a)
		`TESTER_LED_LO: return led_m[7:0];
		`TESTER_LED_HI: return led_m[15:8];
		`TESTER_SW_LO:  return sw[7:0];
		`TESTER_SW_HI:  return sw[15:8];
		`TESTER_PA_SET: return pa_m;
		`TESTER_PA_CLR: return pa_in;
		default:        return `TESTER_UNMAPPED_DATA;
		endcase
	endfunction

	task automatic model_write(input logic [15:0] a, input logic [7:0] d);
		if ((a >> 12) == (`TESTER_SYSRAM_BASE >> 12))
			sys_m[a[11:0]] = d;
		else if ((a >> 12) == (`TESTER_CARTRAM_BASE >> 12))
			cart_m[a[11:0]] = d;
		else if (a == `TESTER_LED_LO)
			led_m[7:0] = d;
		else if (a == `TESTER_LED_HI)
			led_m[15:8] = d;
		else if (a == `TESTER_PA_SET)
			pa_m = pa_m | d;
		else if (a == `TESTER_PA_CLR)
			pa_m = pa_m & ~d;
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %0t %s: got %h, expected %h", $time, name, got, exp);
			mis_errs++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// Host and cartridge transactions.
	// ~~~~~~~~~~~~~~~~~~~~
	task automatic host_write(input logic [15:0] a, input logic [7:0] d, input logic [3:0] s);
		int  n;
		logic done;
		@(negedge cpuclk);
		awaddr = a;
		wdata = {24'ha5c3e1, d}; // Upper lanes are ignored.
		wstrb = s;
		awvalid = 1'b1;
		wvalid = 1'b1;
		n = 0;
		done = 1'b0;
		while (!done && n < TMO) begin
			@(posedge cpuclk);
			done = awready && wready;
			n++;
		end
		if (!done) begin
			$display("Timeout: the host write was never accepted at %0t.", $time);
			other_errs++;
		end
		@(negedge cpuclk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		if (s[0])
			model_write(a, d);
		n = 0;
		done = 1'b0;
		while (!done && n < TMO) begin
			bready = stress ? lfsr_bit() : 1'b1;
			arvalid = stress; // A read waiting behind the response.
			@(posedge cpuclk);
			if (bvalid && (awready || arready)) begin
				$display("A new address was accepted while bvalid was held at %0t.", $time);
				other_errs++;
			end
			done = bvalid && bready;
			if (done)
				check("bresp", bresp, 0);
			n++;
			@(negedge cpuclk);
		end
		bready = 1'b0;
		arvalid = 1'b0;
		if (!done) begin
			$display("Timeout: no write response at %0t.", $time);
			other_errs++;
		end
	endtask

	task automatic host_read(input logic [15:0] a);
		int          n;
		logic        done, seen;
		logic [31:0] held;
		rd_exp.push_back(expect_byte(a));
		@(negedge cpuclk);
		araddr = a;
		arvalid = 1'b1;
		n = 0;
		done = 1'b0;
		while (!done && n < TMO) begin
			@(posedge cpuclk);
			done = arready;
			n++;
		end
		if (!done) begin
			$display("Timeout: the host read was never accepted at %0t.", $time);
			other_errs++;
		end
		@(negedge cpuclk);
		arvalid = 1'b0;
		n = 0;
		done = 1'b0;
		seen = 1'b0;
		held = '0;
		while (!done && n < TMO) begin
			rready = stress ? lfsr_bit() : 1'b1;
			awvalid = stress; // A write waiting behind the response.
			wvalid = stress;
			@(posedge cpuclk);
			if (rvalid) begin
				if (seen)
					check("rdata held", rdata, held);
				if (arready || awready) begin
					$display("A new address was accepted while rvalid was held at %0t.", $time);
					other_errs++;
				end
				held = rdata;
				seen = 1'b1;
			end
			done = rvalid && rready;
			n++;
			@(negedge cpuclk);
		end
		rready = 1'b0;
		awvalid = 1'b0;
		wvalid = 1'b0;
		if (!done) begin
			$display("Timeout: no read data at %0t.", $time);
			other_errs++;
		end
	endtask

	task automatic cart_cycle(input logic [14:0] adr, input logic [7:0] d,
	                          input logic rd, input logic wr,
	                          input logic rom, input logic xram);
		int   n;
		logic qual, done;
		qual = (rd && rom) || (wr && xram && adr[13]);
		@(negedge cpuclk);
		cart_adr = adr;
		cart_data_in = d;
		cart_rd = rd;
		cart_wr = wr;
		cart_cs_rom = rom;
		cart_cs_xram = xram;
		snap_m = {5'b0, wr, rd, xram, d, rom, adr};
		if (qual && wr)
			cart_m[adr[11:0]] = d;
		if (qual)
			cart_exp.push_back({rd, cart_m[adr[11:0]]});
		@(negedge cpuclk);
		cart_rd = 1'b0; // One-cycle strobe.
		cart_wr = 1'b0;
		if (qual) begin
			n = 0;
			done = 1'b0;
			while (!done && n < 8) begin
				@(posedge cpuclk);
				done = cart_done;
				n++;
			end
			if (!done) begin
				$display("Timeout: cart_done never came at %0t.", $time);
				other_errs++;
			end
		end else begin
			repeat (6) @(posedge cpuclk); // No done may appear here.
		end
	endtask

	// Compare process for every read beat and cart_done.
	always @(posedge cpuclk) begin
		if (!f_reset && rvalid && rready) begin
			if (rd_exp.size() == 0) begin
				$display("Read data returned with no read outstanding at %0t.", $time);
				other_errs++;
			end else begin
				check("rdata", rdata, {24'h0, rd_exp.pop_front()});
				check("rresp", rresp, 0);
			end
		end
		if (!f_reset && cart_done) begin
			if (cart_exp.size() == 0) begin
				$display("cart_done pulsed with no qualified strobe at %0t.", $time);
				other_errs++;
			end else begin
				cart_ent = cart_exp.pop_front();
				if (cart_ent[8])
					check("cart_data_out", cart_data_out, cart_ent[7:0]);
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Test sequence.
	// ~~~~~~~~~~~~~~~~~~~~
	initial begin
		lfsr = 32'd90457;
		f_reset = 1'b1;
		awaddr = '0;
		araddr = '0;
		awvalid = 1'b0;
		wvalid = 1'b0;
		arvalid = 1'b0;
		bready = 1'b0;
		rready = 1'b0;
		wdata = '0;
		wstrb = '0;
		cart_adr = '0;
		cart_data_in = '0;
		cart_rd = 1'b0;
		cart_wr = 1'b0;
		cart_cs_rom = 1'b0;
		cart_cs_xram = 1'b0;
		stress = 1'b0;
		mis_errs = 0;
		other_errs = 0;
		led_m = '0;
		pa_m = '0;
		snap_m = '0;
		sw = rand_val(16);
		pa_in = rand_val(8);
		repeat (2) @(posedge cpuclk);
		@(negedge cpuclk);
		f_reset = 1'b0;

		// System RAM round trip.
		for (int i = 0; i < 16; i++) begin
			addr_list[i] = rand_val(12);
			host_write(addr_list[i], rand_val(8), 4'h1);
		end
		for (int i = 0; i < 16; i++)
			host_read(addr_list[i]);

		// LED, switches, unmapped space and lane 0 strobe.
		host_write(`TESTER_LED_LO, rand_val(8), 4'h1);
		host_write(`TESTER_LED_HI, rand_val(8), 4'h1);
		host_write(`TESTER_LED_LO, rand_val(8), 4'he);
		host_write(addr_list[0], rand_val(8), 4'h0);
		check("led", led, led_m);
		host_read(`TESTER_LED_LO);
		host_read(`TESTER_LED_HI);
		host_read(`TESTER_SW_LO);
		host_read(`TESTER_SW_HI);
		host_read(16'hff10);
		host_read(16'h2000);
		host_read(addr_list[0]);

		// Output port set and clear.
		host_write(`TESTER_PA_SET, rand_val(8), 4'h1);
		check("pa_out", pa_out, pa_m);
		host_write(`TESTER_PA_CLR, rand_val(8), 4'h1);
		check("pa_out", pa_out, pa_m);
		host_read(`TESTER_PA_SET);
		host_read(`TESTER_PA_CLR);

		// Cartridge RAM from both sides, then the snapshot.
		for (int i = 0; i < 6; i++) begin
			addr_list[i] = rand_val(12);
			host_write(`TESTER_CARTRAM_BASE | addr_list[i], rand_val(8), 4'h1);
			cart_cycle(addr_list[i], rand_val(8), 1'b1, 1'b0, 1'b1, 1'b0);
			cart_cycle({3'b010, 12'(rand_val(12))}, rand_val(8), 1'b0, 1'b1, 1'b0, 1'b1);
			host_read(`TESTER_CARTRAM_BASE | cart_adr[11:0]);
			cart_cycle({3'b000, addr_list[i][11:0]}, rand_val(8), 1'b0, 1'b1, 1'b0, 1'b1);
			host_read(`TESTER_CARTRAM_BASE | addr_list[i]);
			if (i[0])
				cart_cycle(15'(rand_val(15)) & 15'h5fff, rand_val(8), 1'b0, 1'b1,
				           lfsr_bit(), lfsr_bit()); // Bit 13 clear.
			else
				cart_cycle(rand_val(15), rand_val(8), 1'b1, 1'b0, 1'b0, lfsr_bit());
			for (int k = 0; k < 4; k++)
				host_read(`TESTER_SNAP_BASE + k);
		end

		// Back-pressure with cartridge traffic alongside.
		stress = 1'b1;
		fork
			for (int i = 0; i < 10; i++) begin
				addr_list[i] = rand_val(12);
				host_write(addr_list[i], rand_val(8), 4'h1);
				host_read(addr_list[i]);
			end
			for (int j = 0; j < 10; j++) begin
				cart_cycle({3'b010, 12'(rand_val(12))}, rand_val(8), 1'b0, 1'b1, 1'b0, 1'b1);
				cart_cycle(cart_adr, rand_val(8), 1'b1, 1'b0, 1'b1, 1'b0);
			end
		join
		stress = 1'b0;
		repeat (4) @(posedge cpuclk);

		if (rd_exp.size() != 0 || cart_exp.size() != 0) begin
			$display("Some expected responses never arrived.");
			other_errs++;
		end
		$display("Errors: %0d mismatches, %0d other failures.", mis_errs, other_errs);
		if (mis_errs == 0 && other_errs == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+verilog
verilog/tester_pkg.sv
verilog/local_bus_if.sv
verilog/host_axil_port.sv
verilog/cart_bus_port.sv
verilog/bus_arbiter.sv
verilog/target_map.sv
verilog/cart_tester_top.sv
tb/cart_tester_props.sv
tb/cart_tester_tb.sv

/* verilog/bus_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter(
	input  wire          cpuclk,
	input  wire          f_reset,
	local_bus_if.slave   host_bus,
	local_bus_if.slave   cart_bus,
	local_bus_if.master  mem_bus
);

	logic busy;      // Grant held until the target acks.
	logic owner;     // 1 for the cartridge.
	logic sel_cart;

	// When idle the cartridge wins, otherwise the owner keeps the bus.
	assign sel_cart = busy ? owner : cart_bus.req;

	// ~~~~~~~~~~~~~~~~~~~~
	// Request routing.
	// ~~~~~~~~~~~~~~~~~~~~
	assign mem_bus.req   = sel_cart ? cart_bus.req   : host_bus.req;
	assign mem_bus.we    = sel_cart ? cart_bus.we    : host_bus.we;
	assign mem_bus.addr  = sel_cart ? cart_bus.addr  : host_bus.addr;
	assign mem_bus.wdata = sel_cart ? cart_bus.wdata : host_bus.wdata;

	// Response only to the owner.
	assign cart_bus.ack   = mem_bus.ack && sel_cart;
	assign host_bus.ack   = mem_bus.ack && !sel_cart;
	assign cart_bus.rdata = sel_cart ? mem_bus.rdata : '0;
	assign host_bus.rdata = sel_cart ? '0 : mem_bus.rdata;

	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			busy  <= 1'b0;
			owner <= 1'b0;
		end else if (!busy) begin
			if (cart_bus.req || host_bus.req) begin
				busy  <= 1'b1;
				owner <= cart_bus.req;
			end
		end else if (mem_bus.ack) begin
			busy <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* verilog/cart_bus_port.sv */
`timescale 1ns/10ps
`default_nettype none
`include "tester_defs.svh"

module cart_bus_port(
	input  wire                                cpuclk,
	input  wire                                f_reset,
	input  wire [`TESTER_CART_ADR_W-1:0]       cart_adr,
	input  wire tester_pkg::bus_byte_t         cart_data_in,
	input  wire                                cart_rd,
	input  wire                                cart_wr,
	input  wire                                cart_cs_rom,
	input  wire                                cart_cs_xram,
	output tester_pkg::bus_byte_t              cart_data_out,
	output logic                               cart_done,
	output tester_pkg::cart_snapshot_u         snapshot,
	local_bus_if.master                        bus
);
	import tester_pkg::*;

	logic      strobe, qual_rd, qual_wr;
	logic      req_q, we_q;
	bus_addr_t addr_q;
	bus_byte_t wdata_q;

	assign strobe  = cart_rd || cart_wr;
	assign qual_rd = cart_rd && cart_cs_rom;
	assign qual_wr = cart_wr && cart_cs_xram && cart_adr[13];

	assign bus.req   = req_q;
	assign bus.we    = we_q;
	assign bus.addr  = addr_q;
	assign bus.wdata = wdata_q;

	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			req_q     <= 1'b0;
			cart_done <= 1'b0;
			snapshot  <= '0;
		end else begin
			cart_done <= bus.ack;

			if (bus.ack)
				req_q <= 1'b0;
			else if (qual_rd || qual_wr)
				req_q <= 1'b1;

			// Any strobe is recorded, qualified or not.
			if (strobe) begin
				snapshot.f.cart_adr <= cart_adr;
				snapshot.f.cs_rom   <= cart_cs_rom;
				snapshot.f.data     <= cart_data_in;
				snapshot.f.cs_xram  <= cart_cs_xram;
				snapshot.f.rd       <= cart_rd;
				snapshot.f.wr       <= cart_wr;
				snapshot.f.pad      <= '0;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Request payload and read return.
	// ~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge cpuclk) begin
		if (qual_rd || qual_wr) begin
			we_q    <= qual_wr;
			addr_q  <= `TESTER_CARTRAM_BASE | bus_addr_t'(cart_adr[`TESTER_RAM_AW-1:0]);
			wdata_q <= cart_data_in;
		end

		if (bus.ack && !we_q)
			cart_data_out <= bus.rdata;
	end

endmodule

`default_nettype wire

/* verilog/cart_tester_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "tester_defs.svh"

module cart_tester_top(
	input  wire                              cpuclk,
	input  wire                              f_reset,

	// AXI4-Lite host port.
	input  wire tester_pkg::bus_addr_t       awaddr,
	input  wire                              awvalid,
	output wire                              awready,
	input  wire [`TESTER_AXIL_DATA_W-1:0]    wdata,
	input  wire [`TESTER_AXIL_DATA_W/8-1:0]  wstrb,
	input  wire                              wvalid,
	output wire                              wready,
	output wire [1:0]                        bresp,
	output wire                              bvalid,
	input  wire                              bready,
	input  wire tester_pkg::bus_addr_t       araddr,
	input  wire                              arvalid,
	output wire                              arready,
	output wire [`TESTER_AXIL_DATA_W-1:0]    rdata,
	output wire [1:0]                        rresp,
	output wire                              rvalid,
	input  wire                              rready,

	output wire [15:0]                       led,
	input  wire [15:0]                       sw,
	output wire tester_pkg::bus_byte_t       pa_out,
	input  wire tester_pkg::bus_byte_t       pa_in,

	// Cartridge bus.
	input  wire [`TESTER_CART_ADR_W-1:0]     cart_adr,
	input  wire tester_pkg::bus_byte_t       cart_data_in,
	output wire tester_pkg::bus_byte_t       cart_data_out,
	input  wire                              cart_rd,
	input  wire                              cart_wr,
	input  wire                              cart_cs_rom,
	input  wire                              cart_cs_xram,
	output wire                              cart_done
);
	import tester_pkg::*;

	cart_snapshot_u snapshot;

	local_bus_if host_bus(.cpuclk(cpuclk), .f_reset(f_reset));
	local_bus_if cart_bus(.cpuclk(cpuclk), .f_reset(f_reset));
	local_bus_if mem_bus(.cpuclk(cpuclk), .f_reset(f_reset));

	host_axil_port host_port(
		.cpuclk(cpuclk), .f_reset(f_reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.bus(host_bus)
	);

	cart_bus_port cart_port(
		.cpuclk(cpuclk), .f_reset(f_reset),
		.cart_adr(cart_adr), .cart_data_in(cart_data_in),
		.cart_rd(cart_rd), .cart_wr(cart_wr),
		.cart_cs_rom(cart_cs_rom), .cart_cs_xram(cart_cs_xram),
		.cart_data_out(cart_data_out), .cart_done(cart_done),
		.snapshot(snapshot),
		.bus(cart_bus)
	);

	bus_arbiter arbiter(
		.cpuclk(cpuclk), .f_reset(f_reset),
		.host_bus(host_bus), .cart_bus(cart_bus), .mem_bus(mem_bus)
	);

	target_map map(
		.cpuclk(cpuclk), .f_reset(f_reset),
		.sw(sw), .pa_in(pa_in), .snapshot(snapshot),
		.led(led), .pa_out(pa_out),
		.bus(mem_bus)
	);

endmodule

`default_nettype wire

/* verilog/host_axil_port.sv */
`timescale 1ns/10ps
`default_nettype none
`include "tester_defs.svh"

module host_axil_port(
	input  wire                              cpuclk,
	input  wire                              f_reset,

	input  wire tester_pkg::bus_addr_t       awaddr,
	input  wire                              awvalid,
	output logic                             awready,
	input  wire [`TESTER_AXIL_DATA_W-1:0]    wdata,
	input  wire [`TESTER_AXIL_DATA_W/8-1:0]  wstrb,
	input  wire                              wvalid,
	output logic                             wready,

	output logic [1:0]                       bresp,
	output logic                             bvalid,
	input  wire                              bready,

	input  wire tester_pkg::bus_addr_t       araddr,
	input  wire                              arvalid,
	output logic                             arready,
	output logic [`TESTER_AXIL_DATA_W-1:0]   rdata,
	output logic [1:0]                       rresp,
	output logic                             rvalid,
	input  wire                              rready,

	local_bus_if.master                      bus
);
	import tester_pkg::*;

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_BUS  = 2'd1;
	localparam logic [1:0] S_RESP = 2'd2;
	localparam logic [1:0] RESP_OKAY = 2'b00;

	logic [1:0] state;
	logic       wr_accept, rd_accept;
	logic       is_write;
	bus_addr_t  addr_q;
	bus_byte_t  wdata_q;
	bus_byte_t  rdata_q;

	assign wr_accept = (state == S_IDLE) && awvalid && wvalid;
	assign rd_accept = (state == S_IDLE) && arvalid && !wr_accept; // Writes win ties.

	assign awready = wr_accept;
	assign wready  = wr_accept;
	assign arready = rd_accept;
	assign bresp   = RESP_OKAY;
	assign rresp   = RESP_OKAY;
	assign rdata   = {{(`TESTER_AXIL_DATA_W-`TESTER_DATA_W){1'b0}}, rdata_q};

	assign bus.req   = (state == S_BUS);
	assign bus.we    = is_write;
	assign bus.addr  = addr_q;
	assign bus.wdata = wdata_q;

	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			state  <= S_IDLE;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			case (state)
			S_IDLE:
				if (wr_accept) begin
					if (wstrb[0]) begin
						state <= S_BUS;
					end else begin
						state  <= S_RESP; // Lane 0 off, skip the bus.
						bvalid <= 1'b1;
					end
				end else if (rd_accept) begin
					state <= S_BUS;
				end
			S_BUS:
				if (bus.ack) begin
					state  <= S_RESP;
					bvalid <= is_write;
					rvalid <= !is_write;
				end
			S_RESP:
				if ((bvalid && bready) || (rvalid && rready)) begin
					state  <= S_IDLE;
					bvalid <= 1'b0;
					rvalid <= 1'b0;
				end
			default:
				state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge cpuclk) begin
		if (wr_accept) begin
			is_write <= 1'b1;
			addr_q   <= awaddr;
			wdata_q  <= wdata[`TESTER_DATA_W-1:0];
		end else if (rd_accept) begin
			is_write <= 1'b0;
			addr_q   <= araddr;
		end

		if (state == S_BUS && bus.ack && !is_write)
			rdata_q <= bus.rdata; // Held until rready.
	end

endmodule

`default_nettype wire

/* verilog/local_bus_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface local_bus_if(
	input wire cpuclk,
	input wire f_reset
);
	import tester_pkg::*;

	logic      req;
	logic      we;
	bus_addr_t addr;
	bus_byte_t wdata;
	bus_byte_t rdata;
	logic      ack;   // One cycle, rdata valid with it.

	modport master(
		input  cpuclk, f_reset, ack, rdata,
		output req, we, addr, wdata
	);

	modport slave(
		input  cpuclk, f_reset, req, we, addr, wdata,
		output ack, rdata
	);

endinterface

`default_nettype wire

/* verilog/target_map.sv */
`timescale 1ns/10ps
`default_nettype none
`include "tester_defs.svh"

module target_map(
	input  wire                                 cpuclk,
	input  wire                                 f_reset,
	input  wire [15:0]                          sw,
	input  wire tester_pkg::bus_byte_t          pa_in,
	input  wire tester_pkg::cart_snapshot_u     snapshot,
	output logic [15:0]                         led,
	output tester_pkg::bus_byte_t               pa_out,
	local_bus_if.slave                          bus
);
	import tester_pkg::*;

	localparam logic [1:0] SEL_SYS  = 2'd0;
	localparam logic [1:0] SEL_CART = 2'd1;
	localparam logic [1:0] SEL_REG  = 2'd2;

	bus_byte_t sysram  [0:(1 << `TESTER_RAM_AW)-1];
	bus_byte_t cartram [0:(1 << `TESTER_RAM_AW)-1];

	logic                      ack_q;
	logic                      acc, rd_en, wr_en;
	logic                      in_sys, in_cart, in_snap;
	logic [`TESTER_RAM_AW-1:0] idx;
	bus_byte_t                 reg_byte;
	bus_byte_t                 sys_q, cart_q, reg_q;
	logic [1:0]                sel_q;

	assign acc   = bus.req && !ack_q;
	assign rd_en = acc && !bus.we;
	assign wr_en = acc && bus.we;
	assign idx   = bus.addr[`TESTER_RAM_AW-1:0];

	// ~~~~~~~~~~~~~~~~~~~~
	// Address decode.
	// ~~~~~~~~~~~~~~~~~~~~
	assign in_sys  = (bus.addr >> `TESTER_RAM_AW) == (`TESTER_SYSRAM_BASE >> `TESTER_RAM_AW);
	assign in_cart = (bus.addr >> `TESTER_RAM_AW) == (`TESTER_CARTRAM_BASE >> `TESTER_RAM_AW);
	assign in_snap = (bus.addr >> 2) == (`TESTER_SNAP_BASE >> 2);

	always_comb begin
		reg_byte = `TESTER_UNMAPPED_DATA;

		if (in_snap) begin
			reg_byte = snapshot.b[bus.addr[1:0]];
		end else begin
			case (bus.addr)
			`TESTER_LED_LO: reg_byte = led[7:0];
			`TESTER_LED_HI: reg_byte = led[15:8];
			`TESTER_SW_LO:  reg_byte = sw[7:0];
			`TESTER_SW_HI:  reg_byte = sw[15:8];
			`TESTER_PA_SET: reg_byte = pa_out;
			`TESTER_PA_CLR: reg_byte = pa_in;
			default:        reg_byte = `TESTER_UNMAPPED_DATA;
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Registers and ack.
	// ~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			ack_q  <= 1'b0;
			led    <= '0;
			pa_out <= '0;
		end else begin
			ack_q <= acc; // Exactly one cycle later.

			if (wr_en) begin
				case (bus.addr)
				`TESTER_LED_LO: led[7:0]  <= bus.wdata;
				`TESTER_LED_HI: led[15:8] <= bus.wdata;
				`TESTER_PA_SET: pa_out    <= pa_out | bus.wdata;
				`TESTER_PA_CLR: pa_out    <= pa_out & ~bus.wdata;
				default: ;
				endcase
			end
		end
	end

	// RAMs with registered read ports.
	always_ff @(posedge cpuclk) begin
		if (wr_en && in_sys)
			sysram[idx] <= bus.wdata;
		if (wr_en && in_cart)
			cartram[idx] <= bus.wdata;

		if (rd_en) begin
			sys_q  <= sysram[idx];
			cart_q <= cartram[idx];
			reg_q  <= reg_byte;
			sel_q  <= in_sys ? SEL_SYS : (in_cart ? SEL_CART : SEL_REG);
		end
	end

	assign bus.ack   = ack_q;
	assign bus.rdata = (sel_q == SEL_SYS)  ? sys_q  :
	                   (sel_q == SEL_CART) ? cart_q : reg_q;

endmodule

`default_nettype wire

/* verilog/tester_defs.svh */
`ifndef TESTER_DEFS_SVH
`define TESTER_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Bus widths.
// ~~~~~~~~~~~~~~~~~~~~
`define TESTER_ADDR_W        16
`define TESTER_DATA_W        8
`define TESTER_AXIL_DATA_W   32
`define TESTER_CART_ADR_W    15

// ~~~~~~~~~~~~~~~~~~~~
// Memory map.
// ~~~~~~~~~~~~~~~~~~~~
`define TESTER_RAM_AW        12      // 4 KiB per RAM.
`define TESTER_SYSRAM_BASE   16'h0000
`define TESTER_CARTRAM_BASE  16'h1000
`define TESTER_LED_LO        16'hff00
`define TESTER_LED_HI        16'hff01
`define TESTER_SW_LO         16'hff02
`define TESTER_SW_HI         16'hff03
`define TESTER_PA_SET        16'hff40 // Reads back pa_out.
`define TESTER_PA_CLR        16'hff41 // Reads back pa_in.
`define TESTER_SNAP_BASE     16'hff50 // Four bytes up to 0xff53.

`define TESTER_UNMAPPED_DATA 8'hff

`endif

/* verilog/tester_pkg.sv */
`default_nettype none

package tester_pkg;

	`include "tester_defs.svh"

	typedef logic [`TESTER_ADDR_W-1:0] bus_addr_t;
	typedef logic [`TESTER_DATA_W-1:0] bus_byte_t;

	// ~~~~~~~~~~~~~~~~~~~~
	// Last cartridge bus cycle, LSB first: adr, cs_rom, data, cs_xram, rd, wr.
	// ~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		logic [4:0]                   pad;
		logic                         wr;
		logic                         rd;
		logic                         cs_xram;
		bus_byte_t                    data;
		logic                         cs_rom;
		logic [`TESTER_CART_ADR_W-1:0] cart_adr;
	} cart_snapshot_t;

	// Written as fields by the cartridge port, read as bytes by the map.
	typedef union packed {
		cart_snapshot_t  f;
		bus_byte_t [3:0] b;
	} cart_snapshot_u;

endpackage

`default_nettype wire
